/* common/dcache_pkg.sv */
// dcache shared package: cache geometry, address and line views, lookup and command bundles
package dcache_pkg;

	// ------------------------------
	// geometry
	// ------------------------------
	localparam int dc_word_w         = 32;
	localparam int dc_line_w         = 128;
	localparam int dc_tag_w          = 26;
	localparam int dc_sets           = 4;
	localparam int dc_ways           = 2;
	localparam int dc_words_per_line = 4;

	localparam int dc_index_w     = $clog2(dc_sets);
	localparam int dc_offset_w    = $clog2(dc_words_per_line);
	localparam int dc_way_w       = $clog2(dc_ways);
	localparam int dc_line_addr_w = dc_tag_w + dc_index_w;  // memory side line address
	localparam int dc_stall_cnt_w = 16;

	// ------------------------------
	// address and line views
	// ------------------------------
	// processor word address, msb first
	typedef struct packed {
		logic [dc_tag_w-1:0]    tag;
		logic [dc_index_w-1:0]  index;
		logic [dc_offset_w-1:0] word;
	} dc_addr_t;

	// flat view goes to the memory bus, word view feeds select and merge
	typedef union packed {
		logic [dc_line_w-1:0]                        flat;
		logic [dc_words_per_line-1:0][dc_word_w-1:0] words;  // words[0] is bits 31:0
	} dc_line_u;

	// ------------------------------
	// tag array to controller
	// ------------------------------
	typedef struct packed {
		logic                hit;           // request present and one way matches
		logic [dc_way_w-1:0] hit_way;
		logic [dc_way_w-1:0] victim_way;
		logic                victim_dirty;  // valid and dirty
		logic [dc_tag_w-1:0] victim_tag;
	} dc_lookup_t;

	// controller to both arrays
	typedef struct packed {
		logic                write_word;  // store proc word into hit way
		logic                fill;        // load memory line into victim way
		logic                clean;       // victim written back
		logic [dc_way_w-1:0] way;
	} dc_cmd_t;

	typedef enum logic [1:0] {
		s_lookup     = 2'd0,
		s_write_back = 2'd1,
		s_refill     = 2'd2
	} dc_state_e;

endpackage

/* compile.f */
common/dcache_pkg.sv
hw/stall_counter.sv
dcache/dcache_ctrl.sv
dcache/dcache_tag_array.sv
dcache/dcache_data_array.sv
dcache/dcache_top.sv
dv/slow_mem_model.sv
dv/tb_dcache.sv

/* dcache/dcache_ctrl.sv */
// dcache controller: lookup, write-back and refill sequencing, drives the memory request
`timescale 1ns/1ns

module dcache_ctrl import dcache_pkg::*; (
	input  logic                      clk,
	input  logic                      proc_reset,
	input  logic                      proc_read,
	input  logic                      proc_write,
	input  dc_addr_t                  proc_addr,
	input  dc_lookup_t                lookup,
	input  dc_line_u                  victim_line,
	input  logic                      mem_ready,
	output dc_cmd_t                   cmd,
	output logic                      proc_stall,
	output logic                      mem_read,
	output logic                      mem_write,
	output logic [dc_line_addr_w-1:0] mem_addr,
	output logic [dc_line_w-1:0]      mem_wdata
);

	dc_state_e state;
	dc_state_e state_nxt;
	logic      req;

	assign req       = proc_read || proc_write;
	assign mem_wdata = victim_line.flat;  // sampled by memory only with mem_write

	// ------------------------------
	// state register
	// ------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= s_lookup;
		end else begin
			state <= state_nxt;
		end
	end

	// ------------------------------
	// next state and outputs
	// ------------------------------
	always_comb begin
		state_nxt  = state;
		cmd        = '0;
		proc_stall = 1'b1;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_addr   = {proc_addr.tag, proc_addr.index};  // line of the current access

		case (state)
			s_lookup: begin
				proc_stall = req && !lookup.hit;
				if (proc_stall) begin
					// only a valid dirty victim needs to go out first
					state_nxt = lookup.victim_dirty ? s_write_back : s_refill;
				end else if (proc_write && lookup.hit) begin
					cmd.write_word = 1'b1;
					cmd.way        = lookup.hit_way;
				end
			end

			s_write_back: begin
				mem_write = 1'b1;
				mem_addr  = {lookup.victim_tag, proc_addr.index};  // victim's own address
				if (mem_ready) begin
					cmd.clean = 1'b1;
					cmd.way   = lookup.victim_way;
					state_nxt = s_refill;
				end
			end

			s_refill: begin
				mem_read = 1'b1;
				if (mem_ready) begin
					cmd.fill  = 1'b1;       // line captured on this edge
					cmd.way   = lookup.victim_way;
					state_nxt = s_lookup;   // access hits next cycle
				end
			end

			default: begin
				state_nxt = s_lookup;
			end
		endcase
	end

	// ------------------------------
	// memory handshake checks
	// ------------------------------
	a_rd_wr_excl: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_read && mem_write))
		else $error("dcache_ctrl: mem_read and mem_write both high");

	// request must hold until memory accepts it
	a_req_stable: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_read || mem_write) && !mem_ready |=>
			$stable(mem_read) && $stable(mem_write) && $stable(mem_addr)
			&& (!mem_write || $stable(mem_wdata)))
		else $error("dcache_ctrl: memory request changed before mem_ready");

endmodule

/* dcache/dcache_data_array.sv */
// dcache data array: line storage with word select, word merge on write and line fill
`timescale 1ns/1ns

module dcache_data_array import dcache_pkg::*; (
	input  logic                 clk,
	input  logic                 proc_reset,
	input  dc_addr_t             proc_addr,
	input  logic [dc_word_w-1:0] proc_wdata,
	input  dc_cmd_t              cmd,
	input  logic [dc_way_w-1:0]  hit_way,
	input  logic [dc_way_w-1:0]  victim_way,
	input  dc_line_u             mem_rdata,
	output logic [dc_word_w-1:0] proc_rdata,
	output dc_line_u             victim_line
);

	dc_line_u lines [dc_sets][dc_ways];

	dc_line_u hit_line;
	dc_line_u wr_line;  // next contents of the target line
	logic     wr_en;

	// ------------------------------
	// read side
	// ------------------------------
	assign hit_line    = lines[proc_addr.index][hit_way];
	assign proc_rdata  = hit_line.words[proc_addr.word];
	assign victim_line = lines[proc_addr.index][victim_way];  // write-back data

	// ------------------------------
	// write side
	// ------------------------------
	always_comb begin
		if (cmd.fill) begin
			wr_line = mem_rdata;
		end else begin
			wr_line = lines[proc_addr.index][cmd.way];
		end
		if (cmd.write_word) begin
			wr_line.words[proc_addr.word] = proc_wdata;  // merge one word
		end
	end

	assign wr_en = (cmd.fill || cmd.write_word) && !proc_reset;  // no writes during reset

	always_ff @(posedge clk) begin
		if (wr_en) begin
			lines[proc_addr.index][cmd.way] <= wr_line;
		end
	end

endmodule

/* dcache/dcache_tag_array.sv */
// dcache tag array: valid, dirty, tag and fill-order state with hit detection and victim choice
`timescale 1ns/1ns

module dcache_tag_array import dcache_pkg::*; (
	input  logic       clk,
	input  logic       proc_reset,
	input  logic       proc_read,
	input  logic       proc_write,
	input  dc_addr_t   proc_addr,
	input  dc_cmd_t    cmd,
	output dc_lookup_t lookup
);

	logic [dc_ways-1:0]  valid     [dc_sets];
	logic [dc_ways-1:0]  dirty     [dc_sets];
	logic [dc_tag_w-1:0] tags      [dc_sets][dc_ways];
	logic [dc_way_w-1:0] last_fill [dc_sets];  // way most recently filled

	logic [dc_ways-1:0]  way_hit;
	logic [dc_way_w-1:0] victim;

	assign victim = ~last_fill[proc_addr.index];  // two ways, so the other one

	// ------------------------------
	// lookup
	// ------------------------------
	always_comb begin
		lookup = '0;
		for (int w = 0; w < dc_ways; w++) begin
			way_hit[w] = valid[proc_addr.index][w]
				&& (tags[proc_addr.index][w] == proc_addr.tag);
			if (way_hit[w]) begin
				lookup.hit_way = dc_way_w'(w);
			end
		end
		lookup.hit          = (proc_read || proc_write) && (|way_hit);
		lookup.victim_way   = victim;
		lookup.victim_dirty = valid[proc_addr.index][victim] && dirty[proc_addr.index][victim];
		lookup.victim_tag   = tags[proc_addr.index][victim];
	end

	// ------------------------------
	// state update
	// ------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int s = 0; s < dc_sets; s++) begin
				valid[s]     <= '0;
				dirty[s]     <= '0;
				last_fill[s] <= '1;  // first fill goes to way 0
			end
		end else begin
			if (cmd.fill) begin
				valid[proc_addr.index][cmd.way] <= 1'b1;
				dirty[proc_addr.index][cmd.way] <= 1'b0;
				last_fill[proc_addr.index]      <= cmd.way;
			end
			if (cmd.write_word) begin
				dirty[proc_addr.index][cmd.way] <= 1'b1;
			end
			if (cmd.clean) begin
				dirty[proc_addr.index][cmd.way] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd.fill) begin
			tags[proc_addr.index][cmd.way] <= proc_addr.tag;
		end
	end

	// a refill never installs a tag that is already resident in the set
	a_one_hit: assert property (@(posedge clk) disable iff (proc_reset)
		!(way_hit[0] && way_hit[1]))
		else $error("dcache_tag_array: both ways hit in set %0d", proc_addr.index);

endmodule

/* dcache/dcache_top.sv */
// dcache top: two-way write-back data cache between a word processor port and line memory
`timescale 1ns/1ns

module dcache_top import dcache_pkg::*; (
	input  logic                      clk,
	input  logic                      proc_reset,
	// processor port
	input  logic                      proc_read,
	input  logic                      proc_write,
	input  dc_addr_t                  proc_addr,
	input  logic [dc_word_w-1:0]      proc_wdata,
	output logic [dc_word_w-1:0]      proc_rdata,
	output logic                      proc_stall,
	// line memory port
	output logic                      mem_read,
	output logic                      mem_write,
	output logic [dc_line_addr_w-1:0] mem_addr,
	output logic [dc_line_w-1:0]      mem_wdata,
	input  logic [dc_line_w-1:0]      mem_rdata,
	input  logic                      mem_ready,
	// performance
	output logic [dc_stall_cnt_w-1:0] stall_cycles
);

	dc_lookup_t lookup;
	dc_cmd_t    cmd;
	dc_line_u   victim_line;

	dcache_ctrl dcache_ctrl_inst (
		.clk         (clk),
		.proc_reset  (proc_reset),
		.proc_read   (proc_read),
		.proc_write  (proc_write),
		.proc_addr   (proc_addr),
		.lookup      (lookup),
		.victim_line (victim_line),
		.mem_ready   (mem_ready),
		.cmd         (cmd),
		.proc_stall  (proc_stall),
		.mem_read    (mem_read),
		.mem_write   (mem_write),
		.mem_addr    (mem_addr),
		.mem_wdata   (mem_wdata)
	);

	dcache_tag_array dcache_tag_array_inst (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.cmd        (cmd),
		.lookup     (lookup)
	);

	dcache_data_array dcache_data_array_inst (
		.clk         (clk),
		.proc_reset  (proc_reset),
		.proc_addr   (proc_addr),
		.proc_wdata  (proc_wdata),
		.cmd         (cmd),
		.hit_way     (lookup.hit_way),
		.victim_way  (lookup.victim_way),
		.mem_rdata   (mem_rdata),  // flat bus into the line view
		.proc_rdata  (proc_rdata),
		.victim_line (victim_line)
	);

	stall_counter stall_counter_inst (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_stall   (proc_stall),
		.stall_cycles (stall_cycles)
	);

endmodule

/* dv/slow_mem_model.sv */
// slow line memory: 64 lines with an address-derived fill, answers each request after a random delay
`timescale 1ns/1ns

module slow_mem_model #(
	parameter logic [31:0] seed_init = 32'h1
) (
	input  logic         clk,
	input  logic         proc_reset,
	input  logic         mem_read,
	input  logic         mem_write,
	input  logic [27:0]  mem_addr,
	input  logic [127:0] mem_wdata,
	output logic [127:0] mem_rdata,
	output logic         mem_ready
);

	localparam int num_lines = 64;

	logic [127:0] mem [num_lines];
	integer       seed;
	int           wait_cnt;
	logic         busy;  // request seen, delay running

	// word value from the full word address
	function automatic logic [31:0] fill_word(int line, int word);
		logic [7:0] wa;
		wa = 8'(line * 4 + word);
		return {8'hd5, wa, ~wa, wa ^ 8'h3c};
	endfunction

	initial begin
		seed = seed_init;
		for (int l = 0; l < num_lines; l++) begin
			for (int w = 0; w < 4; w++) begin
				mem[l][w*32 +: 32] = fill_word(l, w);
			end
		end
		mem_rdata = '0;
		mem_ready = 1'b0;
		busy      = 1'b0;
		wait_cnt  = 0;
	end

	// outputs change on the falling edge only
	always @(negedge clk) begin
		if (proc_reset) begin
			mem_ready = 1'b0;
			busy      = 1'b0;
		end else if (mem_ready) begin
			mem_ready = 1'b0;  // one-cycle pulse
			busy      = 1'b0;
		end else if (mem_read || mem_write) begin
			if (!busy) begin
				busy     = 1'b1;
				wait_cnt = 1 + ($unsigned($random(seed)) % 4);  // 1 to 4 cycles
			end
			wait_cnt--;
			if (wait_cnt == 0) begin
				if (mem_write) begin
					mem[mem_addr[5:0]] = mem_wdata;
				end else begin
					mem_rdata = mem[mem_addr[5:0]];
				end
				mem_ready = 1'b1;
			end
		end
	end

endmodule

/* dv/tb_dcache.sv */
// dcache testbench driving a stimulus table against a reference cache model
`timescale 1ns/1ns

module tb_dcache import dcache_pkg::*; ();

	localparam logic [31:0] seed_val = 32'h7316;
	localparam int num_entries  = 21;
	localparam int clk_period   = 20;
	localparam int reset_cycles = 8;
	localparam longint watchdog_ns = longint'(num_entries * 20 + reset_cycles + 10) * clk_period;

	// kind 0 is a hit, 1 a clean miss, 2 a dirty miss
	typedef struct packed {
		logic                wr;
		logic [dc_tag_w-1:0] tag;
		logic [1:0]          index;
		logic [1:0]          word;
		logic [31:0]         wdata;
		logic [1:0]          kind;
	} stim_t;

	typedef struct packed {
		logic         wr;
		logic [27:0]  addr;
		logic [127:0] data;
	} mem_ev_t;

	logic         clk;
	logic         proc_reset;
	logic         proc_read;
	logic         proc_write;
	dc_addr_t     proc_addr;
	logic [31:0]  proc_wdata;
	logic [31:0]  proc_rdata;
	logic         proc_stall;
	logic         mem_read;
	logic         mem_write;
	logic [27:0]  mem_addr;
	logic [127:0] mem_wdata;
	logic [127:0] mem_rdata;
	logic         mem_ready;
	logic [15:0]  stall_cycles;

	stim_t   stim [num_entries];
	mem_ev_t exp_q [$];
	mem_ev_t seen_q [$];
	int      stall_seen;
	int      data_errs;
	int      stall_errs;
	int      traffic_errs;
	int      table_errs;

	// reference cache and memory image
	logic         ref_valid [4][2];
	logic         ref_dirty [4][2];
	logic [25:0]  ref_tag   [4][2];
	logic         ref_last  [4];
	logic [127:0] ref_line  [4][2];
	logic [127:0] ref_mem   [64];

	dcache_top dcache_top_inst (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_read    (proc_read),
		.proc_write   (proc_write),
		.proc_addr    (proc_addr),
		.proc_wdata   (proc_wdata),
		.proc_rdata   (proc_rdata),
		.proc_stall   (proc_stall),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_rdata    (mem_rdata),
		.mem_ready    (mem_ready),
		.stall_cycles (stall_cycles)
	);

	slow_mem_model #(.seed_init(seed_val)) slow_mem_model_inst (
		.clk        (clk),
		.proc_reset (proc_reset),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period/2) clk = ~clk;
	end

	initial begin
		#(watchdog_ns);
		$display("timeout: the cache did not get through the stimulus table in %0d ns",
			watchdog_ns);
		$display("TB FAILED");
		$finish;
	end

	// ------------------------------
	// monitor
	// ------------------------------
	always @(posedge clk) begin
		if (!proc_reset && proc_stall) begin
			stall_seen++;
		end
		if (mem_ready && (mem_read || mem_write)) begin
			seen_q.push_back(mem_ev_t'{mem_write, mem_addr, mem_write ? mem_wdata : 128'h0});
		end
	end

	function automatic logic [31:0] init_word(int line, int word);
		logic [7:0] wa;
		wa = 8'(line * 4 + word);
		return {8'hd5, wa, ~wa, wa ^ 8'h3c};
	endfunction

	task automatic load_table();
		// set 1 with cold miss, hits, write hit, clean and dirty evictions
		stim[0]  = '{1'b0, 26'd2,  2'd1, 2'd0, 32'h0,         2'd1};
		stim[1]  = '{1'b0, 26'd2,  2'd1, 2'd1, 32'h0,         2'd0};
		stim[2]  = '{1'b0, 26'd2,  2'd1, 2'd2, 32'h0,         2'd0};
		stim[3]  = '{1'b0, 26'd2,  2'd1, 2'd3, 32'h0,         2'd0};
		stim[4]  = '{1'b1, 26'd2,  2'd1, 2'd2, 32'hcafe_0002, 2'd0};
		stim[5]  = '{1'b0, 26'd2,  2'd1, 2'd2, 32'h0,         2'd0};
		stim[6]  = '{1'b0, 26'd2,  2'd1, 2'd1, 32'h0,         2'd0};
		stim[7]  = '{1'b0, 26'd5,  2'd1, 2'd0, 32'h0,         2'd1};
		stim[8]  = '{1'b0, 26'd9,  2'd1, 2'd3, 32'h0,         2'd2};
		stim[9]  = '{1'b1, 26'd9,  2'd1, 2'd0, 32'h1234_5678, 2'd0};
		stim[10] = '{1'b0, 26'd2,  2'd1, 2'd2, 32'h0,         2'd1};  // written-back word returns
		stim[11] = '{1'b0, 26'd2,  2'd1, 2'd0, 32'h0,         2'd0};
		stim[12] = '{1'b0, 26'd5,  2'd1, 2'd1, 32'h0,         2'd2};
		stim[13] = '{1'b0, 26'd9,  2'd1, 2'd0, 32'h0,         2'd1};
		// sets 0 and 2 with write misses and another dirty eviction
		stim[14] = '{1'b1, 26'd3,  2'd2, 2'd3, 32'hbeef_0003, 2'd1};
		stim[15] = '{1'b0, 26'd3,  2'd2, 2'd3, 32'h0,         2'd0};
		stim[16] = '{1'b1, 26'd0,  2'd0, 2'd1, 32'h0bad_f00d, 2'd1};
		stim[17] = '{1'b0, 26'd0,  2'd0, 2'd1, 32'h0,         2'd0};
		stim[18] = '{1'b0, 26'd7,  2'd2, 2'd0, 32'h0,         2'd1};
		stim[19] = '{1'b0, 26'd12, 2'd2, 2'd1, 32'h0,         2'd2};
		stim[20] = '{1'b0, 26'd3,  2'd2, 2'd3, 32'h0,         2'd1};
	endtask

	// ------------------------------
	// reference model
	// ------------------------------
	task automatic model_access(input stim_t s, output logic [1:0] kind, output logic [31:0] rdata);
		int way;
		int victim;
		logic [27:0] laddr;
		way   = -1;
		kind  = 2'd0;
		rdata = '0;
		for (int w = 0; w < 2; w++) begin
			if (ref_valid[s.index][w] && ref_tag[s.index][w] == s.tag) begin
				way = w;
			end
		end
		if (way < 0) begin
			victim = ref_last[s.index] ? 0 : 1;  // the way not filled last
			kind   = 2'd1;
			if (ref_valid[s.index][victim] && ref_dirty[s.index][victim]) begin
				kind  = 2'd2;
				laddr = {ref_tag[s.index][victim], s.index};
				ref_mem[laddr[5:0]] = ref_line[s.index][victim];
				exp_q.push_back(mem_ev_t'{1'b1, laddr, ref_line[s.index][victim]});
			end
			laddr = {s.tag, s.index};
			exp_q.push_back(mem_ev_t'{1'b0, laddr, 128'h0});
			ref_line[s.index][victim]  = ref_mem[laddr[5:0]];
			ref_valid[s.index][victim] = 1'b1;
			ref_dirty[s.index][victim] = 1'b0;
			ref_tag[s.index][victim]   = s.tag;
			ref_last[s.index]          = victim[0];
			way = victim;
		end
		if (s.wr) begin
			ref_line[s.index][way][s.word*32 +: 32] = s.wdata;
			ref_dirty[s.index][way] = 1'b1;
		end else begin
			rdata = ref_line[s.index][way][s.word*32 +: 32];
		end
	endtask

	// hold the request until the cache lets it complete
	task automatic do_access(input stim_t s, output logic stalled, output logic [31:0] rdata);
		logic done;
		@(negedge clk);
		proc_read  = !s.wr;
		proc_write = s.wr;
		proc_addr  = {s.tag, s.index, s.word};
		proc_wdata = s.wdata;
		stalled    = 1'b0;
		done       = 1'b0;
		while (!done) begin
			#(clk_period/4);
			if (proc_stall) begin
				stalled = 1'b1;
				@(negedge clk);
			end else begin
				rdata = proc_rdata;
				done  = 1'b1;
				@(posedge clk);  // completing edge
			end
		end
	endtask

	task automatic check_traffic(input int idx);
		assert (seen_q.size() == exp_q.size())
		else begin
			traffic_errs++;
			$display("ERROR %0t: entry %0d saw %0d memory transfers, expected %0d",
				$time, idx, seen_q.size(), exp_q.size());
		end
		for (int k = 0; k < seen_q.size() && k < exp_q.size(); k++) begin
			assert (seen_q[k].wr == exp_q[k].wr && seen_q[k].addr == exp_q[k].addr
				&& seen_q[k].data == exp_q[k].data)
			else begin
				traffic_errs++;
				$display("ERROR %0t: entry %0d xfer %0d got %0b/%h/%h, expected %0b/%h/%h",
					$time, idx, k, seen_q[k].wr, seen_q[k].addr, seen_q[k].data,
					exp_q[k].wr, exp_q[k].addr, exp_q[k].data);
			end
		end
		seen_q.delete();
		exp_q.delete();
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		logic [1:0]  model_kind;
		logic [31:0] exp_rdata;
		logic [31:0] got_rdata;
		logic        stalled;
		proc_reset = 1'b1;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		proc_addr  = '0;
		proc_wdata = '0;
		stall_seen = 0;
		data_errs = 0;
		stall_errs = 0;
		traffic_errs = 0;
		table_errs = 0;
		for (int s = 0; s < 4; s++) begin
			ref_last[s] = 1'b1;
			for (int w = 0; w < 2; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_dirty[s][w] = 1'b0;
			end
		end
		for (int l = 0; l < 64; l++) begin
			for (int w = 0; w < 4; w++) begin
				ref_mem[l][w*32 +: 32] = init_word(l, w);
			end
		end
		load_table();

		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		proc_reset = 1'b0;
		#(clk_period/4);
		assert (stall_cycles == 16'd0)
		else begin
			stall_errs++;
			$display("ERROR %0t: stall_cycles is %0d after reset", $time, stall_cycles);
		end

		for (int i = 0; i < num_entries; i++) begin
			model_access(stim[i], model_kind, exp_rdata);
			do_access(stim[i], stalled, got_rdata);
			assert (model_kind == stim[i].kind)
			else begin
				table_errs++;
				$display("ERROR %0t: entry %0d model gives kind %0d, table says %0d",
					$time, i, model_kind, stim[i].kind);
			end
			assert (stalled == (stim[i].kind != 2'd0))
			else begin
				stall_errs++;
				$display("ERROR %0t: entry %0d stalled=%0b, kind %0d",
					$time, i, stalled, stim[i].kind);
			end
			if (!stim[i].wr) begin
				assert (got_rdata == exp_rdata)
				else begin
					data_errs++;
					$display("ERROR %0t: entry %0d read %h, expected %h",
						$time, i, got_rdata, exp_rdata);
				end
			end
			check_traffic(i);
		end

		@(negedge clk);
		proc_read  = 1'b0;
		proc_write = 1'b0;
		repeat (2) @(negedge clk);
		#(clk_period/4);
		assert (int'(stall_cycles) == stall_seen)
		else begin
			stall_errs++;
			$display("ERROR %0t: stall_cycles %0d, stalled cycles seen %0d",
				$time, stall_cycles, stall_seen);
		end

		$display("errors: data %0d, stall %0d, traffic %0d, table %0d",
			data_errs, stall_errs, traffic_errs, table_errs);
		if (data_errs + stall_errs + traffic_errs + table_errs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* hw/stall_counter.sv */
// stall counter: saturating count of cycles in which the processor is held by the cache
`timescale 1ns/1ns

module stall_counter import dcache_pkg::*; (
	input  logic                      clk,
	input  logic                      proc_reset,
	input  logic                      proc_stall,
	output logic [dc_stall_cnt_w-1:0] stall_cycles
);

	logic at_max;

	assign at_max = &stall_cycles;  // hold at all ones

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			stall_cycles <= '0;
		end else if (proc_stall && !at_max) begin
			stall_cycles <= stall_cycles + 1'b1;
		end
	end

endmodule
